// File: bpPkg.sv
package bpPkg;

	// widths shared by the front end
	typedef logic [31:0] pcT;
	typedef logic [31:0] instrT;
	typedef logic [31:0] wordT;
	typedef logic [5:0] opcodeT;

	// instruction fields used by the resolver
	typedef logic [15:0] offsetT;
	typedef logic [25:0] jumpIdxT;

	// one 2-bit saturating history counter
	typedef logic [1:0] ctrT;

	// opcodes handled at decode
	localparam opcodeT opBeq = 6'b000100;
	localparam opcodeT opBne = 6'b000101;
	localparam opcodeT opJ = 6'b000010;

	// counter encodings, upper bit is the prediction
	// 00 strongly not taken
	localparam ctrT ctrMin = 2'b00;
	// 01 weakly not taken
	localparam ctrT ctrInit = 2'b01;
	// 11 strongly taken
	localparam ctrT ctrMax = 2'b11;

	// first fetch address after reset
	localparam pcT resetPc = 32'h0000_0100;

	// one instruction per fetch
	localparam pcT instrBytes = 32'd4;

endpackage

// File: branchUpdateIf.sv
interface branchUpdateIf;
	import bpPkg::*;

	// strobe for one resolved beq or bne
	logic updValid;
	// address of the branch itself
	pcT updPc;
	// outcome seen at decode
	logic updTaken;
	// taken target, written into the target buffer
	pcT updTarget;

	modport source (
		output updValid,
		output updPc,
		output updTaken,
		output updTarget
	);

	modport sink (
		input updValid,
		input updPc,
		input updTaken,
		input updTarget
	);

endinterface

// File: branchHistoryTable.sv
module branchHistoryTable #(
	parameter int tableDepth = 16
) (
	input logic CLK,
	input logic rstN,
	input bpPkg::pcT lookupPc,
	output logic ctrTaken,
	branchUpdateIf.sink upd
);
	import bpPkg::*;

	localparam int idxW = $clog2(tableDepth);

	ctrT counters [tableDepth];

	logic [idxW-1:0] lookupIdx;
	logic [idxW-1:0] updIdx;
	ctrT updCtr;
	ctrT nextCtr;

	// word address bits select the entry
	assign lookupIdx = lookupPc[idxW+1:2];
	assign updIdx = upd.updPc[idxW+1:2];

	// prediction at fetch is the counter msb
	assign ctrTaken = counters[lookupIdx][1];

	assign updCtr = counters[updIdx];

	// saturating step in the direction of the outcome
	always_comb begin
		nextCtr = updCtr;
		if (upd.updTaken) begin
			if (updCtr != ctrMax) begin
				nextCtr = updCtr + 2'd1;
			end
		end else begin
			if (updCtr != ctrMin) begin
				nextCtr = updCtr - 2'd1;
			end
		end
	end

	// every entry starts weakly not taken
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < tableDepth; i++) begin
				counters[i] <= ctrInit;
			end
		end else if (upd.updValid) begin
			counters[updIdx] <= nextCtr;
		end
	end

endmodule

// File: branchTargetBuffer.sv
module branchTargetBuffer #(
	parameter int tableDepth = 16
) (
	input logic CLK,
	input logic rstN,
	input bpPkg::pcT lookupPc,
	output logic btbHit,
	output bpPkg::pcT btbTarget,
	branchUpdateIf.sink upd
);
	import bpPkg::*;

	localparam int idxW = $clog2(tableDepth);
	// everything above the index is kept as tag
	localparam int tagW = 32 - 2 - idxW;

	logic entryValid [tableDepth];
	logic [tagW-1:0] entryTag [tableDepth];
	pcT entryTarget [tableDepth];

	logic [idxW-1:0] lookupIdx;
	logic [tagW-1:0] lookupTag;
	logic [idxW-1:0] updIdx;
	logic [tagW-1:0] updTag;
	logic allocate;

	assign lookupIdx = lookupPc[idxW+1:2];
	assign lookupTag = lookupPc[31:idxW+2];
	assign updIdx = upd.updPc[idxW+1:2];
	assign updTag = upd.updPc[31:idxW+2];

	// hit needs a live entry with the full upper address
	assign btbHit = entryValid[lookupIdx] && (entryTag[lookupIdx] == lookupTag);
	assign btbTarget = entryTarget[lookupIdx];

	// only taken branches claim an entry
	assign allocate = upd.updValid && upd.updTaken;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < tableDepth; i++) begin
				entryValid[i] <= 1'b0;
			end
		end else if (allocate) begin
			entryValid[updIdx] <= 1'b1;
		end
	end

	// tag and target follow the valid bit
	always_ff @(posedge CLK) begin
		if (allocate) begin
			entryTag[updIdx] <= updTag;
			entryTarget[updIdx] <= upd.updTarget;
		end
	end

endmodule

// File: branchResolver.sv
module branchResolver (
	input logic decodeValid,
	input bpPkg::pcT decodePc,
	input logic decodePredTaken,
	input bpPkg::instrT decodeInstr,
	input bpPkg::wordT decodeRsVal,
	input bpPkg::wordT decodeRtVal,
	output logic redirect,
	output bpPkg::pcT redirectPc,
	branchUpdateIf.source upd
);
	import bpPkg::*;

	opcodeT opcode;
	offsetT offset;
	jumpIdxT jumpIdx;
	pcT seqPc;
	pcT branchTarget;
	pcT jumpTarget;
	logic isBeq;
	logic isBne;
	logic isBranch;
	logic isJump;
	logic operandsEqual;
	logic taken;

	// field split of the decode word
	assign opcode = decodeInstr[31:26];
	assign offset = decodeInstr[15:0];
	assign jumpIdx = decodeInstr[25:0];

	assign isBeq = (opcode == opBeq);
	assign isBne = (opcode == opBne);
	assign isJump = (opcode == opJ);
	assign isBranch = isBeq || isBne;

	assign seqPc = decodePc + instrBytes;

	// word offset, sign extended, relative to the next instruction
	assign branchTarget = seqPc + {{14{offset[15]}}, offset, 2'b00};

	// pseudo-direct jump inside the current 256MB region
	assign jumpTarget = {seqPc[31:28], jumpIdx, 2'b00};

	assign operandsEqual = (decodeRsVal == decodeRtVal);
	assign taken = (isBeq && operandsEqual) || (isBne && !operandsEqual);

	always_comb begin
		redirect = 1'b0;
		redirectPc = seqPc;
		if (decodeValid) begin
			if (isJump) begin
				redirect = 1'b1;
				redirectPc = jumpTarget;
			end else if (isBranch) begin
				redirect = (taken != decodePredTaken);
				redirectPc = taken ? branchTarget : seqPc;
			end else if (decodePredTaken) begin
				// predicted taken on something that is not a branch
				redirect = 1'b1;
				redirectPc = seqPc;
			end
		end
	end

	// train both tables on every valid branch, jumps excluded
	assign upd.updValid = decodeValid && isBranch;
	assign upd.updPc = decodePc;
	assign upd.updTaken = taken;
	assign upd.updTarget = branchTarget;

endmodule

// File: fetchUnit.sv
module fetchUnit (
	input logic CLK,
	input logic rstN,
	input logic btbHit,
	input bpPkg::pcT btbTarget,
	input logic ctrTaken,
	input logic redirect,
	input bpPkg::pcT redirectPc,
	output bpPkg::pcT fetchPc,
	output bpPkg::pcT decodePc,
	output logic decodeValid,
	output logic decodePredTaken
);
	import bpPkg::*;

	pcT seqPc;
	pcT predPc;
	pcT nextPc;
	logic predTaken;

	assign seqPc = fetchPc + instrBytes;

	// follow the buffer only when the counter agrees
	assign predTaken = btbHit && ctrTaken;
	assign predPc = predTaken ? btbTarget : seqPc;

	// correction from decode wins over the prediction
	assign nextPc = redirect ? redirectPc : predPc;

	// program counter
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			fetchPc <= resetPc;
		end else begin
			fetchPc <= nextPc;
		end
	end

	// fetch to decode, squashed on a redirect
	always_ff @(posedge CLK) begin
		if (!rstN || redirect) begin
			decodeValid <= 1'b0;
			decodePredTaken <= 1'b0;
		end else begin
			decodeValid <= 1'b1;
			decodePredTaken <= predTaken;
		end
	end

	// pc travels with its valid bit
	always_ff @(posedge CLK) begin
		decodePc <= fetchPc;
	end

endmodule

// File: branchFrontEnd.sv
module branchFrontEnd #(
	parameter int tableDepth = 16
) (
	input logic CLK,
	input logic rstN,
	input bpPkg::instrT decodeInstr,
	input bpPkg::wordT decodeRsVal,
	input bpPkg::wordT decodeRtVal,
	output bpPkg::pcT fetchPc,
	output bpPkg::pcT decodePc,
	output logic decodeValid,
	output logic mispredict
);
	import bpPkg::*;

	logic btbHit;
	pcT btbTarget;
	logic ctrTaken;
	logic decodePredTaken;
	pcT redirectPc;

	// resolved branch, shared by both tables
	branchUpdateIf updBus ();

	fetchUnit fetch (
		.CLK(CLK),
		.rstN(rstN),
		.btbHit(btbHit),
		.btbTarget(btbTarget),
		.ctrTaken(ctrTaken),
		.redirect(mispredict),
		.redirectPc(redirectPc),
		.fetchPc(fetchPc),
		.decodePc(decodePc),
		.decodeValid(decodeValid),
		.decodePredTaken(decodePredTaken)
	);

	branchTargetBuffer #(
		.tableDepth(tableDepth)
	) btb (
		.CLK(CLK),
		.rstN(rstN),
		.lookupPc(fetchPc),
		.btbHit(btbHit),
		.btbTarget(btbTarget),
		.upd(updBus.sink)
	);

	branchHistoryTable #(
		.tableDepth(tableDepth)
	) bht (
		.CLK(CLK),
		.rstN(rstN),
		.lookupPc(fetchPc),
		.ctrTaken(ctrTaken),
		.upd(updBus.sink)
	);

	// redirect doubles as the mispredict flag
	branchResolver resolver (
		.decodeValid(decodeValid),
		.decodePc(decodePc),
		.decodePredTaken(decodePredTaken),
		.decodeInstr(decodeInstr),
		.decodeRsVal(decodeRsVal),
		.decodeRtVal(decodeRtVal),
		.redirect(mispredict),
		.redirectPc(redirectPc),
		.upd(updBus.source)
	);

endmodule

// File: tbTests.svh
task automatic testSequential;
	pcT expPc;
	curTest = "sequential fetch";
	clearProgram();
	resetDut();
	checkValue("fetchPc after reset", resetPc, fetchPc);
	checkValue("decodeValid after reset", 1'b0, decodeValid);
	checkValue("mispredict after reset", 1'b0, mispredict);
	expPc = resetPc;
	for (int i = 0; i < 12; i++) begin
		stepCycle();
		checkValue("decodePc", expPc, decodePc);
		expPc = expPc + 32'd4;
		checkValue("fetchPc", expPc, fetchPc);
		checkValue("decodeValid", 1'b1, decodeValid);
		checkValue("mispredict", 1'b0, mispredict);
	end
endtask

task automatic testColdBeq;
	pcT brPc;
	pcT target;
	curTest = "cold beq";
	brPc = resetPc + 32'h8;
	target = branchDest(brPc, 16'd5);
	clearProgram();
	storeBranch(brPc, opBeq, 16'd5, 1'b1);
	resetDut();
	waitDecode(brPc);
	checkValue("mispredict with branch in decode", 1'b1, mispredict);
	stepCycle();
	checkValue("fetchPc after redirect", target, fetchPc);
	checkValue("decodeValid after redirect", 1'b0, decodeValid);
	stepCycle();
	checkValue("decodePc at target", target, decodePc);
	checkValue("decodeValid at target", 1'b1, decodeValid);
endtask

// backward beq at 0x120 looping to 0x110, taken on every pass
task automatic testLoopTrain;
	pcT brPc;
	pcT target;
	curTest = "loop training";
	brPc = resetPc + 32'h20;
	target = branchDest(brPc, 16'hfffb);
	clearProgram();
	storeBranch(brPc, opBeq, 16'hfffb, 1'b1);
	resetDut();
	waitDecode(brPc);
	checkValue("mispredict on first pass", 1'b1, mispredict);
	stepCycle();
	checkValue("fetchPc after first pass", target, fetchPc);
	checkValue("decodeValid after first pass", 1'b0, decodeValid);
	for (int pass = 2; pass <= 6; pass++) begin
		waitFetch(brPc);
		setOperands(brPc, 1'b1);
		stepCycle();
		checkValue("predicted fetchPc", target, fetchPc);
		checkValue("decodePc on trained pass", brPc, decodePc);
		checkValue("decodeValid on trained pass", 1'b1, decodeValid);
		checkValue("mispredict on trained pass", 1'b0, mispredict);
	end
endtask

task automatic testLoopExit;
	pcT brPc;
	pcT target;
	pcT jPc;
	curTest = "loop exit";
	brPc = resetPc + 32'h20;
	target = branchDest(brPc, 16'hfffb);
	jPc = brPc + 32'd4;
	clearProgram();
	storeBranch(brPc, opBeq, 16'hfffb, 1'b1);
	// jump back to the loop top once the loop has been left
	storeJump(jPc, target[27:2]);
	resetDut();
	// two taken passes bring the counter to its maximum
	waitDecode(brPc);
	stepCycle();
	waitFetch(brPc);
	stepCycle();
	checkValue("mispredict on second pass", 1'b0, mispredict);
	waitFetch(brPc);
	setOperands(brPc, 1'b0);
	stepCycle();
	checkValue("fetchPc still predicted", target, fetchPc);
	checkValue("mispredict on exit", 1'b1, mispredict);
	stepCycle();
	checkValue("fetchPc after exit", brPc + 32'd4, fetchPc);
	checkValue("decodeValid after exit", 1'b0, decodeValid);
	setOperands(brPc, 1'b1);
	waitDecode(jPc);
	checkValue("mispredict on jump", 1'b1, mispredict);
	stepCycle();
	checkValue("fetchPc after jump", jumpDest(jPc, target[27:2]), fetchPc);
	waitFetch(brPc);
	stepCycle();
	checkValue("fetchPc on retaken pass", target, fetchPc);
	checkValue("decodePc on retaken pass", brPc, decodePc);
	checkValue("mispredict on retaken pass", 1'b0, mispredict);
endtask

task automatic testBneJump;
	pcT eqPc;
	pcT nePc;
	pcT jPc;
	curTest = "bne and jump";
	eqPc = resetPc + 32'h4;
	nePc = resetPc + 32'hc;
	jPc = branchDest(nePc, 16'd4);
	clearProgram();
	storeBranch(eqPc, opBne, 16'd3, 1'b1);
	storeBranch(nePc, opBne, 16'd4, 1'b0);
	storeJump(jPc, 26'h80);
	resetDut();
	waitDecode(eqPc);
	checkValue("mispredict on untaken bne", 1'b0, mispredict);
	stepCycle();
	checkValue("fetchPc after untaken bne", eqPc + 32'h8, fetchPc);
	checkValue("decodeValid after untaken bne", 1'b1, decodeValid);
	waitDecode(nePc);
	checkValue("mispredict on taken bne", 1'b1, mispredict);
	stepCycle();
	checkValue("fetchPc after taken bne", jPc, fetchPc);
	checkValue("decodeValid after taken bne", 1'b0, decodeValid);
	waitDecode(jPc);
	checkValue("mispredict on jump", 1'b1, mispredict);
	stepCycle();
	checkValue("fetchPc after jump", jumpDest(jPc, 26'h80), fetchPc);
	checkValue("decodeValid after jump", 1'b0, decodeValid);
endtask

// File: tbFrontEnd.sv
module tbFrontEnd;
	import bpPkg::*;

	localparam int clkPeriod = 8;
	localparam int resetCycles = 5;
	// the five tests need a few hundred cycles at most
	localparam int watchdogCycles = 2000;
	// longest wait for one address to show up
	localparam int waitLimit = 64;
	localparam instrT nopWord = 32'h0000_0000;

	logic CLK;
	logic rstN;
	instrT decodeInstr;
	wordT decodeRsVal;
	wordT decodeRtVal;
	pcT fetchPc;
	pcT decodePc;
	logic decodeValid;
	logic mispredict;

	// program model keyed by byte address
	instrT progMem [pcT];
	wordT rsMem [pcT];
	wordT rtMem [pcT];

	integer seed;
	string curTest;

	branchFrontEnd #(
		.tableDepth(16)
	) dut (
		.CLK(CLK),
		.rstN(rstN),
		.decodeInstr(decodeInstr),
		.decodeRsVal(decodeRsVal),
		.decodeRtVal(decodeRtVal),
		.fetchPc(fetchPc),
		.decodePc(decodePc),
		.decodeValid(decodeValid),
		.mispredict(mispredict)
	);

	initial begin
		CLK = 1'b0;
		forever #(clkPeriod / 2) CLK = ~CLK;
	end

	// instruction and operands for the pc sitting in decode
	always @(negedge CLK) begin
		if (!$isunknown(decodePc) && progMem.exists(decodePc)) begin
			decodeInstr = progMem[decodePc];
			decodeRsVal = rsMem[decodePc];
			decodeRtVal = rtMem[decodePc];
		end else begin
			decodeInstr = nopWord;
			decodeRsVal = '0;
			decodeRtVal = '0;
		end
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkValue(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			failRun($sformatf("Fail %s, %s: expected %h, actual %h",
				curTest, what, expected, actual));
		end
	endtask

	// outputs are settled one time unit after the falling edge
	task automatic stepCycle;
		@(negedge CLK);
		#1;
	endtask

	// count rising edges so reset covers whole cycles
	task automatic resetDut;
		rstN = 1'b0;
		repeat (resetCycles) @(posedge CLK);
		@(negedge CLK);
		rstN = 1'b1;
		#1;
	endtask

	task automatic clearProgram;
		progMem.delete();
		rsMem.delete();
		rtMem.delete();
	endtask

	task automatic waitFetch(input pcT pc);
		int n;
		n = 0;
		while (fetchPc !== pc) begin
			if (n == waitLimit) begin
				failRun($sformatf("%s: fetch never reached address %h", curTest, pc));
			end
			stepCycle();
			n++;
		end
	endtask

	task automatic waitDecode(input pcT pc);
		int n;
		n = 0;
		while (!(decodeValid === 1'b1 && decodePc === pc)) begin
			if (n == waitLimit) begin
				failRun($sformatf("%s: address %h never reached decode", curTest, pc));
			end
			stepCycle();
			n++;
		end
	endtask

	// taken target is the next instruction plus a signed count of words
	function automatic pcT branchDest(input pcT pc, input logic [15:0] off);
		int words;
		words = $signed(off);
		return pc + 32'd4 + words * 4;
	endfunction

	// region of pc+4 with the word index as byte address inside it
	function automatic pcT jumpDest(input pcT pc, input logic [25:0] idx);
		pcT region;
		region = (pc + 32'd4) & 32'hf000_0000;
		return region | (pcT'(idx) << 2);
	endfunction

	task automatic setOperands(input pcT pc, input logic equalOps);
		wordT rs;
		rs = $random(seed);
		rsMem[pc] = rs;
		// or-ing in bit 0 keeps the pair apart
		rtMem[pc] = equalOps ? rs : rs ^ ($random(seed) | 32'h1);
	endtask

	task automatic storeBranch(input pcT pc, input opcodeT op, input logic [15:0] off,
			input logic equalOps);
		progMem[pc] = {op, 5'd1, 5'd2, off};
		setOperands(pc, equalOps);
	endtask

	task automatic storeJump(input pcT pc, input logic [25:0] idx);
		progMem[pc] = {opJ, idx};
		rsMem[pc] = '0;
		rtMem[pc] = '0;
	endtask

	`include "tbTests.svh"

	initial begin
		seed = 32'h4e95_a5bb;
		rstN = 1'b0;
		decodeInstr = nopWord;
		decodeRsVal = '0;
		decodeRtVal = '0;
		curTest = "startup";
		testSequential();
		testColdBeq();
		testLoopTrain();
		testLoopExit();
		testBneJump();
		$display("SIMULATION PASSED");
		$finish;
	end

	initial begin
		#(watchdogCycles * clkPeriod);
		failRun($sformatf("timeout: tests still running after %0d cycles", watchdogCycles));
	end

endmodule

// File: tb.f
+incdir+.
bpPkg.sv
branchUpdateIf.sv
branchHistoryTable.sv
branchTargetBuffer.sv
branchResolver.sv
fetchUnit.sv
branchFrontEnd.sv
tbFrontEnd.sv
